//--- bench/test_fscpu.sv
`default_nettype none
`timescale 1ns/100ps

`include "fscpu_config.svh"

module test_fscpu;

	localparam int CYCLE_LIMIT = 2000; // loads, moves of up to 27 cycles, approaches of 3 frames

	logic clk = 0, resetn = 0, bpm_init = 0, bpm_wr_en = 0, req_en = 0, ana_done = 0;
	logic lft_valid = 1, rt_valid = 1;
	fscpu_pkg::speed_t bpm_data = '0;
	fscpu_pkg::cmd_t req_cmd = '0;
	fscpu_pkg::param_t req_param0 = '0, req_param1 = '0, req_param2 = '0, req_param3 = '0;
	fscpu_pkg::coord_t lft_edge = '0, rt_edge = '0;
	logic [3:0] motor_state = '0, motor_zpsign = '0, motor_tpsign = '0;
	fscpu_pkg::tab_addr_t bpm_size;
	fscpu_pkg::err_t req_err;
	logic req_done;
	logic [3:0] motor_sel, motor_start, motor_stop, motor_dir;
	fscpu_pkg::speed_t motor_speed [`FSCPU_MOTORS];
	fscpu_pkg::step_t motor_step [`FSCPU_MOTORS];

	fscpu u_fscpu (.*);

	always #10 clk = ~clk;

	logic [31:0] rng = 32'h436e8f1d;
	int errors = 0, tests = 0, test_start_errors = 0, cycles = 0;
	fscpu_pkg::speed_t table_model [`FSCPU_TABLE_DEPTH];
	int table_size = 0; // entries written by the last load
	int wait_cnt [4], run_cnt [4], frame_cnt = 0;
	logic place_req = 0;
	fscpu_pkg::coord_t place_l, place_r, lpos = 8'd20, rpos = 8'd60;
	int start_at, done_at;
	logic [3:0] start_mask, stop_mask, seen_dir;
	logic [3:0] start_sel, done_sel;
	fscpu_pkg::err_t done_err;
	fscpu_pkg::speed_t seen_speed [4];
	fscpu_pkg::step_t seen_step [4];
	fscpu_pkg::step_t app_steps [$];
	int app_pair_bad;

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// stepper drivers and camera, each running step moves a fiber by one pixel
	always @(negedge clk) begin
		if (place_req) begin
			lpos = place_l;
			rpos = place_r;
		end
		for (int i = 0; i < 4; i++) begin
			if (!resetn || motor_stop[i]) begin
				wait_cnt[i] = 0;
				run_cnt[i] = 0;
				motor_state[i] <= 1'b0;
			end else if (motor_start[i]) begin
				wait_cnt[i] = 2;
				run_cnt[i] = motor_step[i];
			end else if (wait_cnt[i] > 0) begin
				wait_cnt[i]--;
				if (wait_cnt[i] == 0 && run_cnt[i] > 0)
					motor_state[i] <= 1'b1;
			end else if (motor_state[i]) begin
				if (i == 0) lpos = motor_dir[0] ? lpos + 1'b1 : lpos - 1'b1;
				if (i == 1) rpos = motor_dir[1] ? rpos + 1'b1 : rpos - 1'b1;
				run_cnt[i]--;
				if (run_cnt[i] == 0)
					motor_state[i] <= 1'b0;
			end
		end
		frame_cnt = (frame_cnt == 39) ? 0 : frame_cnt + 1;
		ana_done <= (frame_cnt == 39);
		lft_edge <= lpos;
		rt_edge  <= rpos;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("run stopped after %0d cycles, a request never completed", cycles);
			$display("Test failures found");
			$finish;
		end
	end

	task automatic check_speed(string name, fscpu_pkg::speed_t got, fscpu_pkg::speed_t exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_step(string name, fscpu_pkg::step_t got, fscpu_pkg::step_t exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_err(string name, fscpu_pkg::err_t got, fscpu_pkg::err_t exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_size(string name, fscpu_pkg::tab_addr_t got, fscpu_pkg::tab_addr_t exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_mask(string name, logic [3:0] got, logic [3:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_cycles(string name, int got, int exp);
		if (got != exp) begin
			$display("** Error at %0t: %s got %0d cycles expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic finish_test(string name);
		tests++;
		$display("test %-10s finished with %0d errors", name, errors - test_start_errors);
		test_start_errors = errors;
	endtask

	task automatic issue(fscpu_pkg::cmd_t cmd, int p0, int p1, int p2, int p3);
		@(negedge clk);
		req_en = 1'b1;
		req_cmd = cmd;
		req_param0 = p0;
		req_param1 = p1;
		req_param2 = p2;
		req_param3 = p3;
	endtask

	// counts falling edges after the request until req_done, noting starts and stops
	task automatic collect();
		int n;
		n = 0;
		start_at = 0;
		start_mask = '0;
		stop_mask = '0;
		start_sel = '0;
		app_pair_bad = 0;
		app_steps.delete();
		do begin
			@(negedge clk);
			req_en = 1'b0;
			n++;
			if (motor_start != 0 && start_at == 0) begin
				start_at = n;
				start_sel = motor_sel;
			end
			start_mask |= motor_start;
			stop_mask |= motor_stop;
			for (int i = 0; i < 4; i++) begin
				if (motor_start[i]) begin
					seen_speed[i] = motor_speed[i];
					seen_step[i] = motor_step[i];
					seen_dir[i] = motor_dir[i];
				end
			end
			if (motor_start[0]) begin
				app_steps.push_back(motor_step[0]);
				if (!motor_start[1] || motor_step[1] != motor_step[0] || motor_dir[1:0] != 2'b01)
					app_pair_bad++;
			end
		end while (!req_done);
		done_at = n;
		done_err = req_err;
		done_sel = motor_sel;
	endtask

	task automatic load_table(int n);
		@(negedge clk) bpm_init = 1'b1;
		@(negedge clk) bpm_init = 1'b0;
		for (int i = 0; i < n; i++) begin
			bpm_wr_en = 1'b1;
			bpm_data = next_rand();
			table_model[i] = bpm_data;
			@(negedge clk);
		end
		bpm_wr_en = 1'b0;
		table_size = n;
		check_size("bpm_size", bpm_size, fscpu_pkg::tab_addr_t'(n));
	endtask

	task automatic do_move(int mot, int idx, int steps, logic dir);
		issue(`CMD_MOVE, mot, idx, steps, dir);
		collect();
		check_cycles("motor_start delay", start_at, 3);
		check_mask("motor_start", start_mask, 4'b0001 << mot);
		check_mask("motor_sel at start", start_sel, 4'b0001 << mot);
		check_speed("motor_speed", seen_speed[mot], table_model[idx]);
		check_step("motor_step", seen_step[mot], fscpu_pkg::step_t'(steps));
		check_mask("motor_dir", {3'b000, seen_dir[mot]}, {3'b000, dir});
		check_cycles("req_done delay", done_at, steps + 7); // 2 to rise, steps, done, req_done
		check_err("req_err", done_err, `ERR_OK);
		check_mask("motor_sel at done", done_sel, 4'b0000);
	endtask

	task automatic expect_reject(string name, fscpu_pkg::err_t exp);
		collect();
		check_cycles({name, " req_done delay"}, done_at, 2);
		check_mask({name, " motor_start"}, start_mask, 4'b0000);
		check_err({name, " req_err"}, done_err, exp);
	endtask

	task automatic do_approach(int gap0, int target);
		fscpu_pkg::step_t exp_steps [$];
		int g, h;
		g = gap0;
		while (g > target) begin
			h = (g - target + 1) / 2;
			exp_steps.push_back(fscpu_pkg::step_t'(h));
			g = g - 2 * h;
		end
		@(negedge clk) begin
			place_l = 8'd20;
			place_r = fscpu_pkg::coord_t'(20 + gap0);
			place_req <= 1'b1;
		end
		@(negedge clk) place_req <= 1'b0;
		issue(`CMD_APPROACH, next_rand() % table_size, target, 0, 0);
		collect();
		check_err("approach req_err", done_err, `ERR_OK);
		check_cycles("approach rounds", app_steps.size(), exp_steps.size());
		check_cycles("approach unpaired starts", app_pair_bad, 0);
		for (int r = 0; r < app_steps.size() && r < exp_steps.size(); r++)
			check_step("approach motor_step", app_steps[r], exp_steps[r]);
	endtask

	initial begin
		int n, mot, steps;
		logic dir;
		repeat (2) @(posedge clk);
		@(negedge clk) resetn = 1'b1;
		check_size("bpm_size after reset", bpm_size, '0);
		check_mask("motor_sel after reset", motor_sel, 4'b0000);

		load_table(5 + next_rand() % 30);
		load_table(8 + next_rand() % 40); // a reload starts counting from zero
		finish_test("load");

		for (int t = 0; t < 6; t++)
			do_move(next_rand() % 4, next_rand() % table_size, 1 + next_rand() % 20, next_rand() & 1);
		finish_test("move");

		issue(4 + next_rand() % 50, 0, 0, 1, 1);
		expect_reject("command", `ERR_CMD);
		issue(`CMD_MOVE, 4 + next_rand() % 100, 0, 1, 1);
		expect_reject("motor", `ERR_MOTOR);
		issue(`CMD_MOVE, next_rand() % 4, table_size + next_rand() % 10, 1, 1);
		expect_reject("speed", `ERR_SPEED);
		mot = next_rand() % 4;
		dir = next_rand() & 1;
		@(negedge clk) begin
			motor_tpsign[mot] = dir;
			motor_zpsign[mot] = !dir;
		end
		issue(`CMD_MOVE, mot, 0, 1, dir);
		expect_reject("limit", `ERR_LIMIT);
		motor_tpsign = '0;
		motor_zpsign = '0;
		finish_test("reject");

		for (int t = 0; t < 3; t++) begin
			n = 2 + next_rand() % 10;
			do_approach(n + next_rand() % 120, n);
		end
		finish_test("approach");

		mot = next_rand() % 4;
		issue(`CMD_MOVE, mot, 0, 200, 1);
		do begin
			@(negedge clk);
			req_en = 1'b0;
		end while (!motor_state[mot]);
		issue(`CMD_STOP, 0, 0, 0, 0);
		collect();
		check_mask("motor_stop", stop_mask, 4'b0001 << mot);
		check_cycles("stop req_done delay", done_at, 2);
		check_err("stop req_err", done_err, `ERR_OK);
		steps = 1 + next_rand() % 20;
		do_move(next_rand() % 4, next_rand() % table_size, steps, next_rand() & 1);
		finish_test("stop");

		@(negedge clk) lft_valid = 1'b0;
		issue(`CMD_APPROACH, 0, 5, 0, 0);
		collect();
		check_err("no edge req_err", done_err, `ERR_NO_EDGE);
		check_mask("no edge motor_start", start_mask, 4'b0000);
		lft_valid = 1'b1;
		finish_test("no_edge");

		$display("%0d tests run, %0d checks failed", tests, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

//--- fscpu.f
+incdir+source
source/fscpu_pkg.sv
source/speed_table.sv
source/edge_gap.sv
source/motor_channel.sv
source/fscpu_ctl.sv
source/fscpu.sv
bench/test_fscpu.sv

//--- run.sh
#!/bin/sh
# builds and runs the fscpu testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f fscpu.f --top-module test_fscpu -o sim_fscpu

status=0
./obj_dir/sim_fscpu > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "All tests passed!" sim.log; then
	echo "simulation result: pass (exit status $status)"
	exit 0
else
	echo "simulation result: fail, see sim.log"
	exit 1
fi

//--- source/edge_gap.sv
`default_nettype none
`timescale 1ns/100ps

module edge_gap (
	input  wire                    clk,
	input  wire                    resetn,
	input  wire                    ana_done,
	input  wire                    lft_valid,
	input  wire fscpu_pkg::coord_t lft_edge,
	input  wire                    rt_valid,
	input  wire fscpu_pkg::coord_t rt_edge,
	output logic                   gap_ready,
	output fscpu_pkg::coord_t      gap,
	output logic                   gap_fault
);

	logic crossed;
	logic fault_now;

	// right fiber seen left of the left fiber, the gap would wrap
	assign crossed   = rt_edge < lft_edge;
	assign fault_now = !lft_valid || !rt_valid || crossed;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			gap_ready <= 1'b0;
			gap_fault <= 1'b0;
		end else begin
			gap_ready <= ana_done;
			if (ana_done)
				gap_fault <= fault_now;
		end
	end

	// gap is only meaningful while gap_fault is low
	always_ff @(posedge clk) begin
		if (ana_done)
			gap <= rt_edge - lft_edge;
	end

endmodule

`default_nettype wire

//--- source/fscpu.sv
`default_nettype none
`timescale 1ns/100ps

`include "fscpu_config.svh"

module fscpu (
	input  wire                        clk,
	input  wire                        resetn,
	input  wire                        bpm_init,
	input  wire                        bpm_wr_en,
	input  wire fscpu_pkg::speed_t     bpm_data,
	output wire fscpu_pkg::tab_addr_t  bpm_size,
	input  wire                        req_en,
	input  wire fscpu_pkg::cmd_t       req_cmd,
	input  wire fscpu_pkg::param_t     req_param0,
	input  wire fscpu_pkg::param_t     req_param1,
	input  wire fscpu_pkg::param_t     req_param2,
	input  wire fscpu_pkg::param_t     req_param3,
	output wire                        req_done,
	output wire fscpu_pkg::err_t       req_err,
	input  wire                        ana_done,
	input  wire                        lft_valid,
	input  wire fscpu_pkg::coord_t     lft_edge,
	input  wire                        rt_valid,
	input  wire fscpu_pkg::coord_t     rt_edge,
	output wire [`FSCPU_MOTORS-1:0]    motor_sel,
	output wire [`FSCPU_MOTORS-1:0]    motor_start,
	output wire [`FSCPU_MOTORS-1:0]    motor_stop,
	output wire fscpu_pkg::speed_t     motor_speed [`FSCPU_MOTORS],
	output wire fscpu_pkg::step_t      motor_step [`FSCPU_MOTORS],
	output wire [`FSCPU_MOTORS-1:0]    motor_dir,
	input  wire [`FSCPU_MOTORS-1:0]    motor_state,
	input  wire [`FSCPU_MOTORS-1:0]    motor_zpsign,
	input  wire [`FSCPU_MOTORS-1:0]    motor_tpsign
);

	wire fscpu_pkg::tab_addr_t tab_rd_addr;
	wire fscpu_pkg::speed_t    tab_speed;
	wire fscpu_pkg::speed_t    ch_speed;
	wire fscpu_pkg::step_t     ch_step;
	wire fscpu_pkg::coord_t    gap;
	wire [`FSCPU_MOTORS-1:0]   ch_go, ch_abort, ch_dir, ch_busy, ch_done;
	wire                       gap_ready, gap_fault;

	fscpu_ctl u_ctl (
		.clk, .resetn,
		.req_en, .req_cmd, .req_param0, .req_param1, .req_param2, .req_param3,
		.bpm_size, .tab_speed, .ch_busy, .ch_done, .motor_zpsign, .motor_tpsign,
		.gap_ready, .gap, .gap_fault,
		.req_done, .req_err, .tab_rd_addr,
		.ch_go, .ch_abort, .ch_speed, .ch_step, .ch_dir
	);

	speed_table u_table (
		.clk, .resetn, .bpm_init, .bpm_wr_en, .bpm_data,
		.rd_addr  (tab_rd_addr),
		.rd_speed (tab_speed),
		.bpm_size
	);

	edge_gap u_gap (
		.clk, .resetn, .ana_done, .lft_valid, .lft_edge, .rt_valid, .rt_edge,
		.gap_ready, .gap, .gap_fault
	);

	genvar i;
	generate
		for (i = 0; i < `FSCPU_MOTORS; i = i + 1) begin : g_motor
			motor_channel u_channel (
				.clk, .resetn,
				.go          (ch_go[i]),
				.abort       (ch_abort[i]),
				.go_speed    (ch_speed),
				.go_step     (ch_step),
				.go_dir      (ch_dir[i]),
				.motor_state (motor_state[i]),
				.busy        (ch_busy[i]),
				.ch_done     (ch_done[i]),
				.motor_sel   (motor_sel[i]),
				.motor_start (motor_start[i]),
				.motor_stop  (motor_stop[i]),
				.motor_speed (motor_speed[i]),
				.motor_step  (motor_step[i]),
				.motor_dir   (motor_dir[i])
			);
		end
	endgenerate

endmodule

`default_nettype wire

//--- source/fscpu_config.svh
`ifndef FSCPU_CONFIG_SVH
`define FSCPU_CONFIG_SVH

`define FSCPU_SPEED_W      32
`define FSCPU_STEP_W       8
`define FSCPU_IMG_W        8
`define FSCPU_TABLE_DEPTH  256
`define FSCPU_TABLE_AW     8

// motor index 0 is left fiber, 1 right fiber, 2 x alignment, 3 y alignment
`define FSCPU_MOTORS       4

`define CMD_MOVE           32'd1
`define CMD_APPROACH       32'd2
`define CMD_STOP           32'd3

`define ERR_OK             32'd0
`define ERR_CMD            32'd1
`define ERR_MOTOR          32'd2
`define ERR_SPEED          32'd3
`define ERR_LIMIT          32'd4
`define ERR_NO_EDGE        32'd5

`endif

//--- source/fscpu_ctl.sv
`default_nettype none
`timescale 1ns/100ps

`include "fscpu_config.svh"

module fscpu_ctl (
	input  wire                        clk,
	input  wire                        resetn,
	input  wire                        req_en,
	input  wire fscpu_pkg::cmd_t       req_cmd,
	input  wire fscpu_pkg::param_t     req_param0,
	input  wire fscpu_pkg::param_t     req_param1,
	input  wire fscpu_pkg::param_t     req_param2,
	input  wire fscpu_pkg::param_t     req_param3,
	input  wire fscpu_pkg::tab_addr_t  bpm_size,
	input  wire fscpu_pkg::speed_t     tab_speed,
	input  wire [`FSCPU_MOTORS-1:0]    ch_busy,
	input  wire [`FSCPU_MOTORS-1:0]    ch_done,
	input  wire [`FSCPU_MOTORS-1:0]    motor_zpsign,
	input  wire [`FSCPU_MOTORS-1:0]    motor_tpsign,
	input  wire                        gap_ready,
	input  wire fscpu_pkg::coord_t     gap,
	input  wire                        gap_fault,
	output logic                       req_done,
	output fscpu_pkg::err_t            req_err,
	output fscpu_pkg::tab_addr_t       tab_rd_addr,
	output logic [`FSCPU_MOTORS-1:0]   ch_go,
	output logic [`FSCPU_MOTORS-1:0]   ch_abort,
	output fscpu_pkg::speed_t          ch_speed,
	output fscpu_pkg::step_t           ch_step,
	output logic [`FSCPU_MOTORS-1:0]   ch_dir
);

	fscpu_pkg::ctl_state_t state;
	fscpu_pkg::cmd_t       cmd_q;
	fscpu_pkg::param_t     p0_q, p1_q, p2_q, p3_q;
	fscpu_pkg::param_t     idx_now, idx_q;
	fscpu_pkg::motor_id_t  mot;
	fscpu_pkg::err_t       chk_err;
	fscpu_pkg::coord_t     excess;
	fscpu_pkg::step_t      half_step;
	logic [`FSCPU_IMG_W:0] excess_up;
	logic [`FSCPU_MOTORS-1:0] go_q;
	logic [1:0] pend; // left and right still moving in this round
	logic [1:0] pend_next;
	logic stop_req, accept, gap_over, app_launch;

	assign stop_req = req_en && (req_cmd == `CMD_STOP);
	assign accept   = stop_req || (req_en && state == fscpu_pkg::IDLE);

	// the speed index is param0 for an approach and param1 for a move
	assign idx_now = (req_cmd == `CMD_APPROACH) ? req_param0 : req_param1;
	assign idx_q   = (cmd_q == `CMD_APPROACH) ? p0_q : p1_q;
	assign tab_rd_addr = (state == fscpu_pkg::IDLE) ? fscpu_pkg::tab_addr_t'(idx_now) :
		fscpu_pkg::tab_addr_t'(idx_q);
	assign mot = fscpu_pkg::motor_id_t'(p0_q);

	always_comb begin
		chk_err = `ERR_OK;
		if (cmd_q == `CMD_MOVE) begin
			if (p0_q >= `FSCPU_MOTORS)
				chk_err = `ERR_MOTOR;
			else if (p1_q >= fscpu_pkg::param_t'(bpm_size))
				chk_err = `ERR_SPEED;
			else if (p3_q[0] ? motor_tpsign[mot] : motor_zpsign[mot])
				chk_err = `ERR_LIMIT;
		end else if (cmd_q == `CMD_APPROACH) begin
			if (p0_q >= fscpu_pkg::param_t'(bpm_size))
				chk_err = `ERR_SPEED;
			else if (motor_tpsign[0] || motor_zpsign[1]) // left forward, right reverse
				chk_err = `ERR_LIMIT;
		end else if (cmd_q != `CMD_STOP) begin
			chk_err = `ERR_CMD;
		end
	end

	// approach target is param1, each side covers half the excess rounded up
	assign gap_over   = fscpu_pkg::param_t'(gap) > p1_q;
	assign excess     = gap - fscpu_pkg::coord_t'(p1_q);
	assign excess_up  = {1'b0, excess} + 1'b1;
	assign half_step  = fscpu_pkg::step_t'(excess_up >> 1);
	assign app_launch = (state == fscpu_pkg::APP_WAIT) && gap_ready && !gap_fault &&
		gap_over && !stop_req;
	assign pend_next  = pend & ~ch_done[1:0];

	assign ch_go    = go_q | {{(`FSCPU_MOTORS-2){1'b0}}, app_launch, app_launch};
	assign ch_speed = tab_speed;
	assign ch_step  = (state == fscpu_pkg::APP_WAIT) ? half_step : fscpu_pkg::step_t'(p2_q);
	assign ch_dir   = (state == fscpu_pkg::APP_WAIT) ? `FSCPU_MOTORS'(1) :
		{`FSCPU_MOTORS{p3_q[0]}};
	assign req_done = (state == fscpu_pkg::DONE);

	always_ff @(posedge clk) begin
		if (accept) begin
			cmd_q <= req_cmd;
			p0_q  <= req_param0;
			p1_q  <= req_param1;
			p2_q  <= req_param2;
			p3_q  <= req_param3;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state    <= fscpu_pkg::IDLE;
			req_err  <= `ERR_OK;
			go_q     <= '0;
			ch_abort <= '0;
			pend     <= '0;
		end else begin
			go_q     <= '0;
			ch_abort <= '0;
			if (stop_req) begin
				ch_abort <= ch_busy | ch_go; // includes a move launched this cycle
				state    <= fscpu_pkg::CHECK;
			end else begin
				case (state)
					fscpu_pkg::IDLE: begin
						if (req_en)
							state <= fscpu_pkg::CHECK;
					end
					fscpu_pkg::CHECK: begin
						req_err <= chk_err;
						state   <= fscpu_pkg::DONE;
						if (chk_err == `ERR_OK && cmd_q == `CMD_MOVE) begin
							go_q[mot] <= 1'b1;
							state     <= fscpu_pkg::MOVE_RUN;
						end else if (chk_err == `ERR_OK && cmd_q == `CMD_APPROACH) begin
							state <= fscpu_pkg::APP_WAIT;
						end
					end
					fscpu_pkg::MOVE_RUN: begin
						if (ch_done[mot])
							state <= fscpu_pkg::DONE;
					end
					fscpu_pkg::APP_WAIT: begin
						if (gap_ready) begin
							if (gap_fault) begin
								req_err <= `ERR_NO_EDGE;
								state   <= fscpu_pkg::DONE;
							end else if (!gap_over) begin
								state <= fscpu_pkg::DONE;
							end else begin
								pend  <= 2'b11;
								state <= fscpu_pkg::APP_RUN;
							end
						end
					end
					fscpu_pkg::APP_RUN: begin
						pend <= pend_next;
						if (pend_next == 2'b00)
							state <= fscpu_pkg::APP_WAIT; // next frame decides
					end
					fscpu_pkg::DONE:
						state <= fscpu_pkg::IDLE;
					default:
						state <= fscpu_pkg::IDLE;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- source/fscpu_pkg.sv
`default_nettype none

`include "fscpu_config.svh"

package fscpu_pkg;

	typedef logic [`FSCPU_SPEED_W-1:0] speed_t;
	typedef logic [`FSCPU_STEP_W-1:0]  step_t;
	typedef logic [`FSCPU_IMG_W-1:0]   coord_t;

	// one bit wider than the address so a full table can be counted
	typedef logic [`FSCPU_TABLE_AW:0]  tab_addr_t;

	typedef logic [1:0]  motor_id_t;
	typedef logic [31:0] cmd_t;
	typedef logic [31:0] err_t;
	typedef logic [31:0] param_t;

	typedef enum logic [2:0] {
		IDLE,
		CHECK,
		MOVE_RUN,
		APP_WAIT,
		APP_RUN,
		DONE
	} ctl_state_t;

endpackage

`default_nettype wire

//--- source/motor_channel.sv
`default_nettype none
`timescale 1ns/100ps

module motor_channel (
	input  wire                    clk,
	input  wire                    resetn,
	input  wire                    go,
	input  wire                    abort,
	input  wire fscpu_pkg::speed_t go_speed,
	input  wire fscpu_pkg::step_t  go_step,
	input  wire                    go_dir,
	input  wire                    motor_state,
	output logic                   busy,
	output logic                   ch_done,
	output logic                   motor_sel,
	output logic                   motor_start,
	output logic                   motor_stop,
	output fscpu_pkg::speed_t      motor_speed,
	output fscpu_pkg::step_t       motor_step,
	output logic                   motor_dir
);

	logic seen_run; // driver has reported busy for this move
	logic launch;

	assign launch = go && !busy;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			busy        <= 1'b0;
			seen_run    <= 1'b0;
			ch_done     <= 1'b0;
			motor_sel   <= 1'b0;
			motor_start <= 1'b0;
			motor_stop  <= 1'b0;
		end else begin
			ch_done     <= 1'b0;
			motor_start <= 1'b0;
			motor_stop  <= 1'b0;

			if (busy && abort) begin
				busy       <= 1'b0;
				seen_run   <= 1'b0;
				motor_sel  <= 1'b0;
				motor_stop <= 1'b1; // no ch_done for an aborted move
			end else if (launch) begin
				busy        <= 1'b1;
				seen_run    <= 1'b0;
				motor_sel   <= 1'b1;
				motor_start <= 1'b1;
			end else if (busy && !seen_run) begin
				if (motor_state)
					seen_run <= 1'b1;
			end else if (busy && !motor_state) begin
				// driver went idle after running, the move is complete
				busy      <= 1'b0;
				seen_run  <= 1'b0;
				motor_sel <= 1'b0;
				ch_done   <= 1'b1;
			end
		end
	end

	// command held steady for the driver until the next launch
	always_ff @(posedge clk) begin
		if (launch) begin
			motor_speed <= go_speed;
			motor_step  <= go_step;
			motor_dir   <= go_dir;
		end
	end

endmodule

`default_nettype wire

//--- source/speed_table.sv
`default_nettype none
`timescale 1ns/100ps

`include "fscpu_config.svh"

module speed_table (
	input  wire                       clk,
	input  wire                       resetn,
	input  wire                       bpm_init,
	input  wire                       bpm_wr_en,
	input  wire fscpu_pkg::speed_t    bpm_data,
	input  wire fscpu_pkg::tab_addr_t rd_addr,
	output fscpu_pkg::speed_t         rd_speed,
	output fscpu_pkg::tab_addr_t      bpm_size
);

	fscpu_pkg::speed_t mem [`FSCPU_TABLE_DEPTH];

	logic                 init_d;
	fscpu_pkg::tab_addr_t wr_ptr;
	logic                 wr_ok;

	// the size counter is also the write pointer, restarted on a new load
	assign wr_ptr = (bpm_init && !init_d) ? '0 : bpm_size;
	assign wr_ok  = bpm_wr_en && (wr_ptr < `FSCPU_TABLE_DEPTH);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			init_d   <= 1'b0;
			bpm_size <= '0;
		end else begin
			init_d <= bpm_init;
			if (wr_ok)
				bpm_size <= wr_ptr + 1'b1;
			else
				bpm_size <= wr_ptr; // writes past a full table are dropped
		end
	end

	always_ff @(posedge clk) begin
		if (wr_ok)
			mem[wr_ptr[`FSCPU_TABLE_AW-1:0]] <= bpm_data;
	end

	// an index beyond the table reads as zero speed
	always_ff @(posedge clk) begin
		if (rd_addr[`FSCPU_TABLE_AW])
			rd_speed <= '0;
		else
			rd_speed <= mem[rd_addr[`FSCPU_TABLE_AW-1:0]];
	end

endmodule

`default_nettype wire
